//--- logic/nice_pkg.sv
////////////////////////////////////////
// Shared definitions for the near-core row accelerator
// Widths, custom-3 field codes, row geometry and operation encoding
////////////////////////////////////////

`default_nettype none

package nice_pkg;

  // Datapath and bus widths
  localparam int unsigned XLEN = 32;
  localparam int unsigned ADDR_W = 32;

  // Row geometry
  localparam int unsigned ROW_LEN = 3;
  localparam int unsigned ROWBUF_DEPTH = 4;
  localparam int unsigned BEAT_IDX_W = 2;
  localparam int unsigned WORD_BYTES = 4;

  // Memory transfer size code, 2 selects a full word
  localparam logic [1:0] SIZE_WORD = 2'd2;

  // Custom-3 major opcode and function fields
  localparam logic [6:0] OPCODE_CUSTOM3 = 7'b1111011;
  localparam logic [2:0] FUNCT3_BUF = 3'b010;
  localparam logic [2:0] FUNCT3_ROWSUM = 3'b110;
  localparam logic [6:0] FUNCT7_LBUF = 7'b0000001;
  localparam logic [6:0] FUNCT7_SBUF = 7'b0000010;
  localparam logic [6:0] FUNCT7_ROWSUM = 7'b0000110;

  typedef logic [XLEN-1:0] nice_word_t;

  // Operation in progress
  // OP_ILLEGAL lives for the single response cycle of an unknown code
  typedef enum logic [2:0] {
    OP_IDLE    = 3'd0,
    OP_LBUF    = 3'd1,
    OP_SBUF    = 3'd2,
    OP_ROWSUM  = 3'd3,
    OP_ILLEGAL = 3'd4
  } nice_op_e;

endpackage

`default_nettype wire

//--- logic/nice_seq_ctrl.sv
////////////////////////////////////////
// Instruction sequencer
// Decodes custom-3 requests, runs the operation FSM,
// counts memory beats and drives the CPU response
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module nice_seq_ctrl import nice_pkg::*; (
  input  logic                  nice_clk,
  input  logic                  nice_rst_n,
  input  logic                  req_valid,
  input  nice_word_t            req_inst,
  input  logic                  rsp_ready,
  input  logic                  icb_rsp_valid,
  input  logic                  icb_rsp_err,
  input  nice_word_t            sum,
  output logic                  req_ready,
  output logic                  rsp_valid,
  output nice_word_t            rsp_rdat,
  output logic                  rsp_err,
  output nice_op_e              op,
  output logic                  start,
  output logic [BEAT_IDX_W-1:0] beat_idx,
  output logic                  mem_holdup
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  nice_op_e   dec_op;
  logic       req_hs;
  logic       rsp_hs;
  logic       mem_op;
  logic       last_seen;
  logic       icb_beat;
  logic       err_q;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // R-type fields
  assign opcode = req_inst[6:0];
  assign funct3 = req_inst[14:12];
  assign funct7 = req_inst[31:25];

  // Anything not matching a row instruction is answered as illegal
  always_comb
  begin
    dec_op = OP_ILLEGAL;
    if (opcode == OPCODE_CUSTOM3)
    begin
      if ((funct3 == FUNCT3_BUF) && (funct7 == FUNCT7_LBUF))
        dec_op = OP_LBUF;
      else if ((funct3 == FUNCT3_BUF) && (funct7 == FUNCT7_SBUF))
        dec_op = OP_SBUF;
      else if ((funct3 == FUNCT3_ROWSUM) && (funct7 == FUNCT7_ROWSUM))
        dec_op = OP_ROWSUM;
    end
  end

  ////////////////////////////////////////
  // Handshakes and status
  ////////////////////////////////////////

  // Only one instruction in flight, accept when idle
  assign req_ready = (op == OP_IDLE);
  assign req_hs    = req_valid & req_ready;
  assign start     = req_hs;

  assign mem_op     = (op == OP_LBUF) | (op == OP_SBUF) | (op == OP_ROWSUM);
  assign mem_holdup = mem_op;

  // All beats of the row are back
  assign last_seen = (beat_idx == BEAT_IDX_W'(ROW_LEN));
  assign icb_beat  = mem_op & icb_rsp_valid & ~last_seen;

  // Response the cycle after the last beat, or straight away for illegal
  assign rsp_valid = (op == OP_ILLEGAL) | (mem_op & last_seen);
  assign rsp_hs    = rsp_valid & rsp_ready;
  assign rsp_rdat  = (op == OP_ROWSUM) ? sum : '0;
  assign rsp_err   = err_q | (op == OP_ILLEGAL);

  ////////////////////////////////////////
  // Operation FSM
  ////////////////////////////////////////

  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
      op <= OP_IDLE;
    else if (req_hs)
      op <= dec_op;
    else if (rsp_hs)
      op <= OP_IDLE;
  end

  // Beat counter, saturates at ROW_LEN and holds until the next start
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
      beat_idx <= '0;
    else if (start)
      beat_idx <= '0;
    else if (icb_beat)
      beat_idx <= beat_idx + 1'b1;
  end

  // Sticky bus error over the row
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
      err_q <= 1'b0;
    else if (start)
      err_q <= 1'b0;
    else if (icb_beat && icb_rsp_err)
      err_q <= 1'b1;
  end

  // Stalled response keeps its payload until the CPU takes it
  a_rsp_stable: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdat) && $stable(rsp_err)));

  // Memory never returns more beats than were asked for
  a_beat_bound: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (mem_op && icb_rsp_valid) |-> !last_seen);

endmodule

`default_nettype wire

//--- logic/nice_mem_port.sv
////////////////////////////////////////
// Memory command port
// Issues the three word commands of a row with address stepping
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module nice_mem_port import nice_pkg::*; (
  input  logic                  nice_clk,
  input  logic                  nice_rst_n,
  input  nice_op_e              op,
  input  logic                  start,
  input  nice_word_t            req_rs1,
  input  logic                  icb_cmd_ready,
  input  nice_word_t            rd_data,
  output logic                  icb_cmd_valid,
  output logic [ADDR_W-1:0]     icb_cmd_addr,
  output logic                  icb_cmd_read,
  output nice_word_t            icb_cmd_wdata,
  output logic [1:0]            icb_cmd_size,
  output logic [BEAT_IDX_W-1:0] rd_idx
);

  logic [ADDR_W-1:0]     addr_q;
  logic [BEAT_IDX_W-1:0] issue_cnt;
  logic                  mem_op;
  logic                  issue_done;
  logic                  cmd_hs;

  assign mem_op     = (op == OP_LBUF) | (op == OP_SBUF) | (op == OP_ROWSUM);
  assign issue_done = (issue_cnt == BEAT_IDX_W'(ROW_LEN));
  assign cmd_hs     = icb_cmd_valid & icb_cmd_ready;

  ////////////////////////////////////////
  // Command fields
  ////////////////////////////////////////

  // First command the cycle after start, since op turns over then
  assign icb_cmd_valid = mem_op & ~issue_done;
  assign icb_cmd_addr  = addr_q;
  // Only sbuf writes
  assign icb_cmd_read  = (op != OP_SBUF);
  assign icb_cmd_wdata = (op == OP_SBUF) ? rd_data : '0;
  assign icb_cmd_size  = SIZE_WORD;

  // Row buffer entry k goes out with command k
  assign rd_idx = issue_cnt;

  ////////////////////////////////////////
  // Address and issue count
  ////////////////////////////////////////

  // Base from rs1 at start, one word further per accepted command
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
      addr_q <= '0;
    else if (start)
      addr_q <= ADDR_W'(req_rs1);
    else if (cmd_hs)
      addr_q <= addr_q + ADDR_W'(WORD_BYTES);
  end

  // Stops at ROW_LEN and so closes cmd_valid
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
      issue_cnt <= '0;
    else if (start)
      issue_cnt <= '0;
    else if (cmd_hs)
      issue_cnt <= issue_cnt + 1'b1;
  end

  // Stalled command holds all its fields, row buffer included
  a_cmd_hold: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    (icb_cmd_valid && !icb_cmd_ready) |=>
      (icb_cmd_valid && $stable(icb_cmd_addr) && $stable(icb_cmd_read) &&
       $stable(icb_cmd_wdata)));

endmodule

`default_nettype wire

//--- logic/nice_row_buf.sv
////////////////////////////////////////
// Four-entry row buffer
// Filled by lbuf responses, read by sbuf commands
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module nice_row_buf import nice_pkg::*; (
  input  logic                  nice_clk,
  input  logic                  nice_rst_n,
  input  nice_op_e              op,
  input  logic                  icb_rsp_valid,
  input  nice_word_t            icb_rsp_rdata,
  input  logic [BEAT_IDX_W-1:0] beat_idx,
  input  logic [BEAT_IDX_W-1:0] rd_idx,
  output nice_word_t            rd_data
);

  nice_word_t rows [ROWBUF_DEPTH];
  logic       wr_en;

  // Each lbuf beat lands at the current beat index
  assign wr_en = (op == OP_LBUF) & icb_rsp_valid;

  // sbuf before any lbuf sees zeros
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      for (int i = 0; i < ROWBUF_DEPTH; i++)
        rows[i] <= '0;
    end
    else if (wr_en)
    begin
      rows[beat_idx] <= icb_rsp_rdata;
    end
  end

  // Combinational read path to the command port
  assign rd_data = rows[rd_idx];

  // Write index from the beat counter stays inside the row
  a_wr_idx: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    wr_en |-> (beat_idx < BEAT_IDX_W'(ROW_LEN)));

endmodule

`default_nettype wire

//--- logic/nice_row_accum.sv
////////////////////////////////////////
// Row sum accumulator
// Adds each rowsum response word into a registered total
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module nice_row_accum import nice_pkg::*; (
  input  logic       nice_clk,
  input  logic       nice_rst_n,
  input  nice_op_e   op,
  input  logic       start,
  input  logic       icb_rsp_valid,
  input  nice_word_t icb_rsp_rdata,
  output nice_word_t sum
);

  nice_word_t acc_q;
  logic       acc_en;

  // Only rowsum beats count toward the total
  assign acc_en = (op == OP_ROWSUM) & icb_rsp_valid;

  // Cleared on every accepted instruction
  // Wraps modulo 2^32, matching rdat
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
      acc_q <= '0;
    else if (start)
      acc_q <= '0;
    else if (acc_en)
      acc_q <= acc_q + icb_rsp_rdata;
  end

  // Registered result, final once the last beat is in
  assign sum = acc_q;

endmodule

`default_nettype wire

//--- logic/nice_core_top.sv
////////////////////////////////////////
// Near-core accelerator top level
// Joins sequencer, memory port, row buffer and row accumulator
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module nice_core_top import nice_pkg::*; (
  input  logic              nice_clk,
  input  logic              nice_rst_n,
  output logic              nice_mem_holdup,
  // CPU request channel
  input  logic              nice_req_valid,
  output logic              nice_req_ready,
  input  nice_word_t        nice_req_inst,
  input  nice_word_t        nice_req_rs1,
  input  nice_word_t        nice_req_rs2,
  // CPU response channel
  output logic              nice_rsp_valid,
  input  logic              nice_rsp_ready,
  output nice_word_t        nice_rsp_rdat,
  output logic              nice_rsp_err,
  // Memory command channel
  output logic              nice_icb_cmd_valid,
  input  logic              nice_icb_cmd_ready,
  output logic [ADDR_W-1:0] nice_icb_cmd_addr,
  output logic              nice_icb_cmd_read,
  output nice_word_t        nice_icb_cmd_wdata,
  output logic [1:0]        nice_icb_cmd_size,
  // Memory response channel
  input  logic              nice_icb_rsp_valid,
  output logic              nice_icb_rsp_ready,
  input  nice_word_t        nice_icb_rsp_rdata,
  input  logic              nice_icb_rsp_err
);

  nice_op_e               op;
  logic                   start;
  logic [BEAT_IDX_W-1:0]  beat_idx;
  logic [BEAT_IDX_W-1:0]  rd_idx;
  nice_word_t             rd_data;
  nice_word_t             sum;

  // Responses are always taken, no buffering needed on this side
  assign nice_icb_rsp_ready = 1'b1;

  // rs2 carries no operand for the three row instructions

  nice_seq_ctrl u_seq_ctrl (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .req_valid     (nice_req_valid),
    .req_inst      (nice_req_inst),
    .rsp_ready     (nice_rsp_ready),
    .icb_rsp_valid (nice_icb_rsp_valid),
    .icb_rsp_err   (nice_icb_rsp_err),
    .sum           (sum),
    .req_ready     (nice_req_ready),
    .rsp_valid     (nice_rsp_valid),
    .rsp_rdat      (nice_rsp_rdat),
    .rsp_err       (nice_rsp_err),
    .op            (op),
    .start         (start),
    .beat_idx      (beat_idx),
    .mem_holdup    (nice_mem_holdup)
  );

  nice_mem_port u_mem_port (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .op            (op),
    .start         (start),
    .req_rs1       (nice_req_rs1),
    .icb_cmd_ready (nice_icb_cmd_ready),
    .rd_data       (rd_data),
    .icb_cmd_valid (nice_icb_cmd_valid),
    .icb_cmd_addr  (nice_icb_cmd_addr),
    .icb_cmd_read  (nice_icb_cmd_read),
    .icb_cmd_wdata (nice_icb_cmd_wdata),
    .icb_cmd_size  (nice_icb_cmd_size),
    .rd_idx        (rd_idx)
  );

  nice_row_buf u_row_buf (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .op            (op),
    .icb_rsp_valid (nice_icb_rsp_valid),
    .icb_rsp_rdata (nice_icb_rsp_rdata),
    .beat_idx      (beat_idx),
    .rd_idx        (rd_idx),
    .rd_data       (rd_data)
  );

  nice_row_accum u_row_accum (
    .nice_clk      (nice_clk),
    .nice_rst_n    (nice_rst_n),
    .op            (op),
    .start         (start),
    .icb_rsp_valid (nice_icb_rsp_valid),
    .icb_rsp_rdata (nice_icb_rsp_rdata),
    .sum           (sum)
  );

endmodule

`default_nettype wire

//--- tests/nice_mem_model.sv
////////////////////////////////////////
// In-order memory responder for the testbench
// 64 words, random command stall and response delay
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module nice_mem_model import nice_pkg::*; (
  input  logic        nice_clk,
  input  logic        nice_rst_n,
  // Command side, ready comes from the testbench generator
  input  logic        cmd_valid,
  input  logic        cmd_ready,
  input  logic [31:0] cmd_addr,
  input  logic        cmd_read,
  input  nice_word_t  cmd_wdata,
  input  logic [1:0]  delay,
  input  logic        err_in,
  // Backdoor for preload and final compare
  input  logic        bk_we,
  input  logic [5:0]  bk_addr,
  input  nice_word_t  bk_wdata,
  output nice_word_t  bk_rdata,
  // Response side
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output nice_word_t  rsp_rdata,
  output logic        rsp_err
);

  nice_word_t  mem [64];
  nice_word_t  q_data [$];
  logic        q_err [$];
  int unsigned q_due [$];
  int unsigned cyc;

  assign bk_rdata = mem[bk_addr];

  // Word address wraps inside the 64 entries
  always @(posedge nice_clk)
  begin
    if (bk_we)
      mem[bk_addr] <= bk_wdata;
    else if (cmd_valid && cmd_ready && !cmd_read)
      mem[cmd_addr[7:2]] <= cmd_wdata;
  end

  ////////////////////////////////////////
  // Response queue
  ////////////////////////////////////////

  always @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      cyc = 0;
      q_data.delete();
      q_err.delete();
      q_due.delete();
      rsp_valid <= 1'b0;
      rsp_rdata <= '0;
      rsp_err   <= 1'b0;
    end
    else
    begin
      cyc = cyc + 1;
      // Head was shown this cycle and taken
      if (rsp_valid && rsp_ready)
      begin
        void'(q_data.pop_front());
        void'(q_err.pop_front());
        void'(q_due.pop_front());
      end
      // Read data is taken at command time, so order follows commands
      if (cmd_valid && cmd_ready)
      begin
        q_data.push_back(cmd_read ? mem[cmd_addr[7:2]] : '0);
        q_err.push_back(err_in);
        q_due.push_back(cyc + delay);
      end
      if ((q_due.size() > 0) && (q_due[0] <= cyc))
      begin
        rsp_valid <= 1'b1;
        rsp_rdata <= q_data[0];
        rsp_err   <= q_err[0];
      end
      else
      begin
        rsp_valid <= 1'b0;
        rsp_rdata <= '0;
        rsp_err   <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/nice_tb.sv
////////////////////////////////////////
// Testbench for the near-core accelerator
// Random row instructions checked against a reference model
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module nice_tb import nice_pkg::*; ();

  localparam int N_INSTR    = 60;
  localparam int MAX_CYCLES = N_INSTR * 40;

  logic        nice_clk = 1'b0;
  logic        nice_rst_n;
  logic        nice_mem_holdup;
  logic        nice_req_valid;
  logic        nice_req_ready;
  nice_word_t  nice_req_inst;
  nice_word_t  nice_req_rs1;
  nice_word_t  nice_req_rs2;
  logic        nice_rsp_valid;
  logic        nice_rsp_ready;
  nice_word_t  nice_rsp_rdat;
  logic        nice_rsp_err;
  logic        nice_icb_cmd_valid;
  logic        nice_icb_cmd_ready;
  logic [31:0] nice_icb_cmd_addr;
  logic        nice_icb_cmd_read;
  nice_word_t  nice_icb_cmd_wdata;
  logic [1:0]  nice_icb_cmd_size;
  logic        nice_icb_rsp_valid;
  logic        nice_icb_rsp_ready;
  nice_word_t  nice_icb_rsp_rdata;
  logic        nice_icb_rsp_err;
  // Memory model controls
  logic [1:0]  mem_delay;
  logic        mem_err;
  logic        bk_we;
  logic [5:0]  bk_addr;
  nice_word_t  bk_wdata;
  nice_word_t  bk_rdata;
  // Reference state
  logic [31:0] lfsr_q = 32'd57;
  nice_word_t  model_mem [64];
  nice_word_t  row_copy [3];
  int          errors = 0;
  int          cycle_cnt = 0;
  logic [31:0] r;

  always #4 nice_clk = ~nice_clk;

  nice_core_top UUT (.*);

  nice_mem_model u_mem (
    .nice_clk   (nice_clk),
    .nice_rst_n (nice_rst_n),
    .cmd_valid  (nice_icb_cmd_valid),
    .cmd_ready  (nice_icb_cmd_ready),
    .cmd_addr   (nice_icb_cmd_addr),
    .cmd_read   (nice_icb_cmd_read),
    .cmd_wdata  (nice_icb_cmd_wdata),
    .delay      (mem_delay),
    .err_in     (mem_err),
    .bk_we      (bk_we),
    .bk_addr    (bk_addr),
    .bk_wdata   (bk_wdata),
    .bk_rdata   (bk_rdata),
    .rsp_valid  (nice_icb_rsp_valid),
    .rsp_ready  (nice_icb_rsp_ready),
    .rsp_rdata  (nice_icb_rsp_rdata),
    .rsp_err    (nice_icb_rsp_err)
  );

  // Run limit
  always @(posedge nice_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $fatal(1, "Timeout");
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // cmd_ready low 1/4, delay 0..3, bus error 1/16, rsp_ready low 1/4
  task automatic drive_random_inputs();
    logic [31:0] v;
    nice_icb_cmd_ready = (rand_bits(2) != 32'd3);
    v = rand_bits(2);
    mem_delay = v[1:0];
    mem_err = (rand_bits(4) == 32'd15);
    nice_rsp_ready = (rand_bits(2) != 32'd3);
  endtask

  // R-type word, sel 15 is an unknown funct7
  function automatic nice_word_t encode_inst(input logic [3:0] sel);
    logic [6:0] f7;
    logic [2:0] f3;
    f3 = FUNCT3_BUF;
    f7 = FUNCT7_LBUF;
    if (sel == 4'hf)
      f7 = 7'b1010101;
    else if (sel % 3 == 1)
      f7 = FUNCT7_SBUF;
    else if (sel % 3 == 2)
    begin
      f7 = FUNCT7_ROWSUM;
      f3 = FUNCT3_ROWSUM;
    end
    return {f7, 5'd2, 5'd1, f3, 5'd3, OPCODE_CUSTOM3};
  endfunction

  ////////////////////////////////////////
  // One instruction, cycle by cycle
  ////////////////////////////////////////

  task automatic run_instr(input logic [3:0] sel, input logic [5:0] widx);
    logic       is_ill;
    logic       is_mem;
    logic       is_wr;
    logic       is_sum;
    logic       accepted;
    logic       done;
    logic       exp_err;
    logic       exp_rsp;
    logic [5:0] idx;
    nice_word_t base;
    nice_word_t exp_sum;
    nice_word_t exp_wdata [3];
    int         n_cmd;
    int         n_rsp;
    is_ill  = (sel == 4'hf);
    is_mem  = !is_ill;
    is_wr   = is_mem && (sel % 3 == 1);
    is_sum  = is_mem && (sel % 3 == 2);
    base    = {24'd0, widx, 2'b00};
    exp_sum = '0;
    // Effect of the row on the memory and row buffer copies
    for (int k = 0; k < 3; k++)
    begin
      idx = widx + 6'(k);
      exp_sum = exp_sum + model_mem[idx];
      exp_wdata[k] = is_wr ? row_copy[k] : '0;
      if (is_wr)
        model_mem[idx] = row_copy[k];
      else if (is_mem && !is_sum)
        row_copy[k] = model_mem[idx];
    end
    nice_req_valid = 1'b1;
    nice_req_inst  = encode_inst(sel);
    nice_req_rs1   = base;
    nice_req_rs2   = ~base;
    drive_random_inputs();
    accepted = 1'b0;
    done     = 1'b0;
    exp_err  = is_ill;
    n_cmd    = 0;
    n_rsp    = 0;
    while (!done)
    begin
      @(negedge nice_clk);
      if (!accepted)
      begin
        // Idle, so the request goes in at the next edge
        check_value("nice_req_ready", nice_req_ready, 1);
        check_value("nice_mem_holdup", nice_mem_holdup, 0);
        check_value("nice_rsp_valid", nice_rsp_valid, 0);
        check_value("nice_icb_cmd_valid", nice_icb_cmd_valid, 0);
        accepted = 1'b1;
      end
      else
      begin
        check_value("nice_req_ready", nice_req_ready, 0);
        check_value("nice_mem_holdup", nice_mem_holdup, is_mem);
        check_value("nice_icb_rsp_ready", nice_icb_rsp_ready, 1);
        check_value("nice_icb_cmd_valid", nice_icb_cmd_valid, is_mem && (n_cmd < 3));
        if (nice_icb_cmd_valid)
        begin
          check_value("nice_icb_cmd_addr", nice_icb_cmd_addr, base + 32'(4 * n_cmd));
          check_value("nice_icb_cmd_read", nice_icb_cmd_read, !is_wr);
          check_value("nice_icb_cmd_size", nice_icb_cmd_size, SIZE_WORD);
          check_value("nice_icb_cmd_wdata", nice_icb_cmd_wdata, exp_wdata[n_cmd]);
          if (nice_icb_cmd_ready)
          begin
            exp_err = exp_err | mem_err;
            n_cmd++;
          end
        end
        // Response only after the third memory beat was taken
        exp_rsp = is_ill || (n_rsp == 3);
        check_value("nice_rsp_valid", nice_rsp_valid, exp_rsp);
        if (exp_rsp)
        begin
          check_value("nice_rsp_rdat", nice_rsp_rdat, is_sum ? exp_sum : '0);
          check_value("nice_rsp_err", nice_rsp_err, exp_err);
          done = nice_rsp_ready;
        end
        // Memory beats seen so far
        if (nice_icb_rsp_valid)
          n_rsp++;
      end
      @(posedge nice_clk);
      #1;
      nice_req_valid = 1'b0;
      drive_random_inputs();
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    nice_rst_n         = 1'b0;
    nice_req_valid     = 1'b0;
    nice_req_inst      = '0;
    nice_req_rs1       = '0;
    nice_req_rs2       = '0;
    nice_rsp_ready     = 1'b0;
    nice_icb_cmd_ready = 1'b0;
    mem_delay          = '0;
    mem_err            = 1'b0;
    bk_we              = 1'b0;
    bk_addr            = '0;
    bk_wdata           = '0;
    for (int k = 0; k < 3; k++)
      row_copy[k] = '0;
    repeat (5) @(posedge nice_clk);
    #1;
    nice_rst_n = 1'b1;
    @(negedge nice_clk);
    check_value("nice_req_ready", nice_req_ready, 1);
    check_value("nice_rsp_valid", nice_rsp_valid, 0);
    check_value("nice_icb_cmd_valid", nice_icb_cmd_valid, 0);
    check_value("nice_mem_holdup", nice_mem_holdup, 0);
    check_value("nice_icb_rsp_ready", nice_icb_rsp_ready, 1);
    // Memory preload through the backdoor
    @(posedge nice_clk);
    #1;
    for (int i = 0; i < 64; i++)
    begin
      r = rand_bits(32);
      bk_we = 1'b1;
      bk_addr = 6'(i);
      bk_wdata = r;
      model_mem[i] = r;
      @(posedge nice_clk);
      #1;
    end
    bk_we = 1'b0;
    for (int n = 0; n < N_INSTR; n++)
    begin
      r = rand_bits(10);
      run_instr(r[9:6], r[5:0]);
    end
    @(negedge nice_clk);
    check_value("nice_req_ready", nice_req_ready, 1);
    check_value("nice_rsp_valid", nice_rsp_valid, 0);
    check_value("nice_icb_cmd_valid", nice_icb_cmd_valid, 0);
    // Final memory image against the model
    for (int i = 0; i < 64; i++)
    begin
      bk_addr = 6'(i);
      #1;
      check_value("memory word", bk_rdata, model_mem[i]);
    end
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
logic/nice_pkg.sv
logic/nice_seq_ctrl.sv
logic/nice_mem_port.sv
logic/nice_row_buf.sv
logic/nice_row_accum.sv
logic/nice_core_top.sv
tests/nice_mem_model.sv
tests/nice_tb.sv

//--- Makefile
# Verilator build and run of the accelerator testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := nice_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "Simulation ended without a verdict"; exit 1)
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
